/* sources.f */
design/memPkg.sv
design/slowMemory.sv
design/cacheLookup.sv
design/missHandler.sv
design/memSubsystem.sv
verification/memSubsystemTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = memSubsystemTb
FILELIST  = sources.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* verification/memSubsystemTb.sv */
`timescale 1ns/1ns

module memSubsystemTb;

  localparam int waitCycles  = 2;
  localparam int lineBits    = 3;
  localparam int memWordBits = 10;

  // 2 + 4 + 8 directed requests ahead of the random run
  localparam int randomRequests = 200;
  localparam int numRequests    = 14 + randomRequests;
  localparam int timeoutCycles  = numRequests * (waitCycles + 10) + 100;

  // address step to the next tag on the same index
  localparam memPkg::addrT tagStep = 32'(1) << (lineBits + 4);

  logic           clk;
  logic           arstN;
  logic           start;
  memPkg::cpuReqT req;
  logic           busy;
  logic           done;
  memPkg::wordT   rdata;

  // shadow copy of main memory, cleared at start
  memPkg::wordT shadow [0:2**memWordBits-1];

  // request in flight as seen by the compare process
  logic         pending;
  logic         expWrite;
  logic         expHit;
  memPkg::wordT expData;
  int           startCycle;
  int           cycle;

  memSubsystem #(
    .waitCycles(waitCycles),
    .lineBits(lineBits),
    .memWordBits(memWordBits)
  ) UUT (
    .clk(clk),
    .arstN(arstN),
    .start(start),
    .req(req),
    .busy(busy),
    .done(done),
    .rdata(rdata)
  );

  always #5 clk = ~clk;

  // expected read data straight from the shadow words
  function automatic memPkg::wordT expectedWord(input memPkg::addrT addr);
    return shadow[addr[memWordBits+1:2]];
  endfunction

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic checkWord(input string name, input memPkg::wordT got, input memPkg::wordT exp);
    if (got !== exp)
      abortRun($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic checkLevel(input string name, input logic got, input logic exp);
    if (got !== exp)
      abortRun($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  // one request and a wait until the compare side saw done
  task automatic issueRequest(input logic write, input memPkg::addrT addr,
                              input memPkg::wordT wdata, input logic hit);
    @(posedge clk);
    #1;
    req.write  = write;
    req.addr   = addr;
    req.wdata  = wdata;
    start      = 1'b1;
    expWrite   = write;
    expHit     = hit;
    startCycle = cycle;
    if (write)
      shadow[addr[memWordBits+1:2]] = wdata;
    else
      expData = expectedWord(addr);
    pending = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
    wait (!pending);
  endtask

  // cycle count and run limit
  always @(posedge clk)
  begin
    cycle <= cycle + 1;
    if (cycle >= timeoutCycles)
      abortRun($sformatf("timeout after %0d cycles, done never arrived", cycle));
  end

  // outputs are stable mid-cycle
  always @(negedge clk)
  begin
    if (arstN)
    begin
      // busy from the cycle after start through the done cycle
      checkLevel("busy", busy, pending && (cycle > startCycle));
      if (done)
      begin
        if (!pending)
          abortRun("done pulsed with no request outstanding");
        if (expHit && (cycle - startCycle != 1))
          abortRun($sformatf("read hit took %0d cycles instead of one",
                             cycle - startCycle));
        if (!expWrite)
          checkWord("rdata", rdata, expData);
        pending = 1'b0;
      end
    end
  end

  initial
  begin
    memPkg::addrT addrA;
    memPkg::addrT addrB;
    memPkg::addrT addrC;
    memPkg::addrT addrD;
    memPkg::addrT randAddr;
    memPkg::wordT randData;
    logic         randWrite;

    void'($urandom(32'hc47d));
    clk        = 1'b0;
    arstN      = 1'b0;
    start      = 1'b0;
    req        = '0;
    pending    = 1'b0;
    expWrite   = 1'b0;
    expHit     = 1'b0;
    expData    = '0;
    startCycle = 0;
    cycle      = 0;
    for (int i = 0; i < 2**memWordBits; i++)
      shadow[i] = '0;

    addrA = 32'h0000_0040;
    // index 0 with nothing cached there yet
    addrB = 32'h0000_0104;
    // C and D collide on one line
    addrC = 32'h0000_002c;
    addrD = addrC + tagStep;

    repeat (5) @(posedge clk);
    #1;
    arstN = 1'b1;

    // quiet window after reset with busy and done low
    repeat (6) @(posedge clk);

    // cold miss and then the same word as a hit
    issueRequest(1'b0, addrA, '0, 1'b0);
    issueRequest(1'b0, addrA, '0, 1'b1);

    // write-through on a cached line and on an uncached one
    issueRequest(1'b1, addrA, 32'hdead_beef, 1'b0);
    issueRequest(1'b0, addrA, '0, 1'b1);
    issueRequest(1'b1, addrB, 32'h1234_5678, 1'b0);
    issueRequest(1'b0, addrB, '0, 1'b0);

    // ping-pong on one index with evictions in between
    issueRequest(1'b0, addrC, '0, 1'b0);
    issueRequest(1'b0, addrD, '0, 1'b0);
    issueRequest(1'b1, addrC, 32'h0bad_cafe, 1'b0);
    issueRequest(1'b0, addrC, '0, 1'b0);
    issueRequest(1'b1, addrD, 32'h5a5a_a5a5, 1'b0);
    issueRequest(1'b0, addrD, '0, 1'b0);
    issueRequest(1'b0, addrC, '0, 1'b0);
    issueRequest(1'b0, addrD, '0, 1'b0);

    // 128 words give four tags per index
    for (int n = 0; n < randomRequests; n++)
    begin
      randAddr  = ($urandom % 128) << 2;
      randData  = $urandom;
      randWrite = ($urandom % 2) == 0;
      issueRequest(randWrite, randAddr, randData, 1'b0);
    end

    repeat (3) @(posedge clk);
    $display("RESULT: PASS");
    $finish;
  end

endmodule

/* design/memSubsystem.sv */
`timescale 1ns/1ns

module memSubsystem #(
  parameter int waitCycles  = 2,
  parameter int lineBits    = 3,
  parameter int memWordBits = 10
) (
  input  logic           clk,
  input  logic           arstN,
  input  logic           start,
  input  memPkg::cpuReqT req,
  output logic           busy,
  output logic           done,
  output memPkg::wordT   rdata
);

  // lookup <-> miss handler
  logic           missGo;
  memPkg::cpuReqT pendReq;
  logic           refillGo;
  logic           missDone;
  memPkg::blockT  refillBlock;

  // miss handler <-> main memory
  memPkg::memReqT memReq;
  logic           valid;
  memPkg::blockT  rd;

  cacheLookup #(
    .lineBits(lineBits)
  ) lookup (
    .clk(clk),
    .arstN(arstN),
    .start(start),
    .req(req),
    .busy(busy),
    .done(done),
    .rdata(rdata),
    .missGo(missGo),
    .pendReq(pendReq),
    .refillGo(refillGo),
    .missDone(missDone),
    .refillBlock(refillBlock)
  );

  missHandler miss (
    .clk(clk),
    .arstN(arstN),
    .missGo(missGo),
    .pendReq(pendReq),
    .memReq(memReq),
    .valid(valid),
    .rd(rd),
    .refillGo(refillGo),
    .missDone(missDone),
    .refillBlock(refillBlock)
  );

  slowMemory #(
    .waitCycles(waitCycles),
    .memWordBits(memWordBits)
  ) mainMem (
    .clk(clk),
    .arstN(arstN),
    .memReq(memReq),
    .rd(rd),
    .valid(valid)
  );

endmodule

/* design/missHandler.sv */
`timescale 1ns/1ns

module missHandler (
  input  logic           clk,
  input  logic           arstN,
  input  logic           missGo,
  input  memPkg::cpuReqT pendReq,
  output memPkg::memReqT memReq,
  input  logic           valid,
  input  memPkg::blockT  rd,
  output logic           refillGo,
  output logic           missDone,
  output memPkg::blockT  refillBlock
);

  memPkg::missStateT state;
  memPkg::missStateT nextState;
  memPkg::addrT      blockAddr;
  logic              memActive;

  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
      state <= memPkg::missIdle;
    else
      state <= nextState;
  end

  // idle -> wait for memory -> finish pulse
  always_comb
  begin
    nextState = state;
    unique case (state)
      memPkg::missIdle:
        if (missGo)
          nextState = memPkg::missWait;
      memPkg::missWait:
        if (valid)
          nextState = memPkg::missFinish;
      memPkg::missFinish:
        nextState = memPkg::missIdle;
      default:
        nextState = memPkg::missIdle;
    endcase
  end

  // reads fetch the aligned block
  assign blockAddr = {pendReq.addr[31:4], 4'b0000};

  // request level stays up through the valid cycle
  assign memActive = (state == memPkg::missWait);

  always_comb
  begin
    memReq.re    = memActive && !pendReq.write;
    memReq.we    = memActive && pendReq.write;
    memReq.addr  = pendReq.write ? pendReq.addr : blockAddr;
    memReq.wdata = pendReq.wdata;
  end

  // block captured on valid, rd follows the held address
  always_ff @(posedge clk)
  begin
    if (memActive && valid)
      refillBlock <= rd;
  end

  // one completion pulse per access
  assign refillGo = (state == memPkg::missFinish) && !pendReq.write;
  assign missDone = (state == memPkg::missFinish) && pendReq.write;

endmodule

/* design/cacheLookup.sv */
`timescale 1ns/1ns

module cacheLookup #(
  parameter int lineBits = 3
) (
  input  logic           clk,
  input  logic           arstN,
  input  logic           start,
  input  memPkg::cpuReqT req,
  output logic           busy,
  output logic           done,
  output memPkg::wordT   rdata,
  output logic           missGo,
  output memPkg::cpuReqT pendReq,
  input  logic           refillGo,
  input  logic           missDone,
  input  memPkg::blockT  refillBlock
);

  // address split: tag | index | word | byte
  localparam int lines   = 2**lineBits;
  localparam int tagBits = 32 - 4 - lineBits;

  typedef logic [lineBits-1:0] indexT;
  typedef logic [tagBits-1:0]  tagT;
  typedef logic [1:0]          wordSelT;

  memPkg::cpuReqT reqQ;
  logic           lookupQ;
  logic           busyQ;
  indexT          index;
  tagT            tag;
  wordSelT        wordSel;
  logic           tagMatch;
  logic           readHit;
  memPkg::blockT  lineData;

  logic [lines-1:0] validQ;
  tagT              tagArr  [0:lines-1];
  memPkg::blockT    dataArr [0:lines-1];

  // request payload, taken on start
  always_ff @(posedge clk)
  begin
    if (start)
      reqQ <= req;
  end

  // lookup flag lives for one cycle after start
  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
    begin
      lookupQ <= 1'b0;
      busyQ   <= 1'b0;
    end
    else
    begin
      lookupQ <= start;
      if (start)
        busyQ <= 1'b1;
      else if (done)
        busyQ <= 1'b0;
    end
  end

  assign index   = reqQ.addr[lineBits+3:4];
  assign tag     = reqQ.addr[31:lineBits+4];
  assign wordSel = reqQ.addr[3:2];

  assign lineData = dataArr[index];
  assign tagMatch = validQ[index] && (tagArr[index] == tag);

  // only reads can complete without main memory
  assign readHit = lookupQ && tagMatch && !reqQ.write;
  assign missGo  = lookupQ && !readHit;

  assign done    = readHit || refillGo || missDone;
  assign busy    = busyQ;
  assign pendReq = reqQ;

  // refilled block wins over the stale line
  assign rdata = refillGo ? refillBlock[wordSel] : lineData[wordSel];

  // valid bits, set by refills
  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
      validQ <= '0;
    else if (refillGo)
      validQ[index] <= 1'b1;
  end

  // tag and data arrays
  always_ff @(posedge clk)
  begin
    if (refillGo)
    begin
      tagArr[index]  <= tag;
      dataArr[index] <= refillBlock;
    end
    // write-through, cached copy follows only on a hit
    else if (missDone && tagMatch)
      dataArr[index][wordSel] <= reqQ.wdata;
  end

endmodule

/* design/slowMemory.sv */
`timescale 1ns/1ns

module slowMemory #(
  parameter int waitCycles  = 2,
  parameter int memWordBits = 10
) (
  input  logic           clk,
  input  logic           arstN,
  input  memPkg::memReqT memReq,
  output memPkg::blockT  rd,
  output logic           valid
);

  // counter wide enough to reach waitCycles
  localparam int countBits = $clog2(waitCycles + 1) + 1;

  typedef logic [countBits-1:0]   countT;
  typedef logic [memWordBits-1:0] wordAddrT;

  memPkg::memStateT state;
  memPkg::memStateT nextState;
  countT            count;
  wordAddrT         wordAddr;
  memPkg::wordT     mem [0:2**memWordBits-1];

  // contents start cleared
  initial
  begin
    for (int i = 0; i < 2**memWordBits; i++)
      mem[i] = '0;
  end

  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
      state <= memPkg::memIdle;
    else
      state <= nextState;
  end

  // idle -> requested -> retrieved -> idle
  always_comb
  begin
    nextState = state;
    unique case (state)
      memPkg::memIdle:
        if (memReq.re || memReq.we)
          nextState = memPkg::memRequested;
      memPkg::memRequested:
        if (count == countT'(waitCycles))
          nextState = memPkg::memRetrieved;
      memPkg::memRetrieved:
        nextState = memPkg::memIdle;
      default:
        nextState = memPkg::memIdle;
    endcase
  end

  // wait counter, held at zero outside requested
  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
      count <= '0;
    else if (state != memPkg::memRequested)
      count <= '0;
    else if (count != countT'(waitCycles))
      count <= count + 1'b1;
  end

  // one pulse per access
  assign valid = (state == memPkg::memRetrieved);

  assign wordAddr = memReq.addr[memWordBits+1:2];

  // whole aligned block, word 0 first
  always_comb
  begin
    for (int i = 0; i < memPkg::blockWords; i++)
      rd[i] = mem[{wordAddr[memWordBits-1:2], 2'(i)}];
  end

  // word write lands when the access completes
  always_ff @(posedge clk)
  begin
    if (state == memPkg::memRetrieved && memReq.we)
      mem[wordAddr] <= memReq.wdata;
  end

endmodule

/* design/memPkg.sv */
package memPkg;

  // one data word and one byte address
  typedef logic [31:0] wordT;
  typedef logic [31:0] addrT;

  // words per cache block and per memory burst
  localparam int blockWords = 4;

  // word 0 sits in the most significant slot
  typedef wordT [0:blockWords-1] blockT;

  // processor request, sampled with start
  typedef struct packed {
    logic write;
    addrT addr;
    wordT wdata;
  } cpuReqT;

  // main memory request, held as a level until valid
  typedef struct packed {
    logic re;
    logic we;
    addrT addr;
    wordT wdata;
  } memReqT;

  // miss handler FSM
  typedef enum logic [1:0] {missIdle, missWait, missFinish} missStateT;

  // main memory FSM
  typedef enum logic [1:0] {memIdle, memRequested, memRetrieved} memStateT;

endpackage
